//--- include/bflyConsts.svh
// Butterfly network constants
`ifndef BFLY_CONSTS_SVH
`define BFLY_CONSTS_SVH

// Initiators and targets, same count on both sides
`define BFLY_NUM_PORTS 8

// One address bit is consumed per stage
`define BFLY_ADDR_W 3

// One index bit is collected per stage
`define BFLY_IDX_W 3

// Radix-2 network, so one stage per address bit
`define BFLY_STAGES `BFLY_ADDR_W

// Payload widths
`define BFLY_REQ_DATA_W 32
`define BFLY_RESP_DATA_W 32

`endif

//--- run.sh
#!/bin/sh
# Build and run the butterfly network testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module butterflyNetTb \
  -f tb.f --Mdir obj_dir -o simv > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/simv > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log

grep -qx "Verification passed" sim.log \
  && { echo "Run result: PASS"; exit 0; } \
  || { echo "Run result: FAIL"; exit 1; }

//--- sim/butterflyNetTb.sv
// Butterfly network testbench
`timescale 1ns/1ps
`default_nettype none

`include "bflyConsts.svh"

module butterflyNetTb;

  import bflyPkg::*;

  localparam int NumPorts  = `BFLY_NUM_PORTS;
  localparam int ClkPeriod = 8;

  // Cycle budgets of the tests
  localparam int BudgetReset        = 16;
  localparam int BudgetSingle       = 24;
  localparam int BudgetPerm         = 24;
  localparam int BudgetContend      = 40;
  localparam int BudgetResp         = 24;
  localparam int BudgetBackPressure = 8;
  localparam int WatchdogNs = (BudgetReset + BudgetSingle + BudgetPerm + BudgetContend
                               + BudgetResp + BudgetBackPressure) * 2 * ClkPeriod;

  logic                           clk_i = 1'b0;
  logic                           reset_i;
  logic      [NumPorts-1:0]       req_i;
  addr_t     [NumPorts-1:0]       add_i;
  reqData_t  [NumPorts-1:0]       wdata_i;
  logic      [NumPorts-1:0]       gnt_o;
  logic      [NumPorts-1:0]       vld_o;
  respData_t [NumPorts-1:0]       rdata_o;
  logic      [NumPorts-1:0]       rdy_i;
  logic      [NumPorts-1:0]       req_o;
  idx_t      [NumPorts-1:0]       idx_o;
  reqData_t  [NumPorts-1:0]       wdata_o;
  logic      [NumPorts-1:0]       gnt_i;
  logic      [NumPorts-1:0]       vld_i;
  idx_t      [NumPorts-1:0]       idx_i;
  respData_t [NumPorts-1:0]       rdata_i;
  logic      [NumPorts-1:0]       rdy_o;

  // Expected round-robin state, one step per edge with an accepted request
  prio_t prioModel;

  int errors      = 0;
  int testsPassed = 0;
  int testsFailed = 0;

  butterflyNet DUT (
    .clk_i  (clk_i  ),
    .reset_i(reset_i),
    .req_i  (req_i  ),
    .add_i  (add_i  ),
    .wdata_i(wdata_i),
    .gnt_o  (gnt_o  ),
    .vld_o  (vld_o  ),
    .rdata_o(rdata_o),
    .rdy_i  (rdy_i  ),
    .req_o  (req_o  ),
    .idx_o  (idx_o  ),
    .wdata_o(wdata_o),
    .gnt_i  (gnt_i  ),
    .vld_i  (vld_i  ),
    .idx_i  (idx_i  ),
    .rdata_i(rdata_i),
    .rdy_o  (rdy_o  )
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (reset_i) begin
      prioModel <= '0;
    end else if (|(req_o & gnt_i)) begin
      prioModel <= prioModel + prio_t'(1);
    end
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
    $display("Verification failed");
    $finish;
  end

  task automatic checkEq(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic endTest(input string name, input int startErrors);
    if (errors == startErrors) begin
      testsPassed++;
      $display("PASS %s", name);
    end else begin
      testsFailed++;
      $display("FAIL %s (%0d errors)", name, errors - startErrors);
    end
  endtask

  task automatic clearInputs();
    req_i   <= '0;
    add_i   <= '0;
    wdata_i <= '0;
    gnt_i   <= '0;
    vld_i   <= '0;
    idx_i   <= '0;
    rdata_i <= '0;
    rdy_i   <= '0;
  endtask

  // Two requests for one target first share the switchbox of stage (2 - d),
  // d being their lowest differing bit, and arrive there on input number bit d
  function automatic int predictWinner(input int a, input int b, input prio_t prio);
    int diff;
    int d;
    diff = a ^ b;
    d    = 0;
    for (int i = `BFLY_STAGES - 1; i >= 0; i--) begin
      if (((diff >> i) & 1) != 0) d = i;
    end
    if (((a >> d) & 1) == int'(prio[d])) return a;
    return b;
  endfunction

  task automatic idleAfterReset();
    int startErrors;
    startErrors = errors;
    @(negedge clk_i);
    checkEq("req_o", req_o, 0);
    checkEq("gnt_o", gnt_o, 0);
    checkEq("vld_o", vld_o, 0);
    checkEq("rdy_o", rdy_o, 0);
    endTest("reset idle", startErrors);
  endtask

  task automatic singleRequests();
    int startErrors;
    int t;
    logic [31:0] data;
    startErrors = errors;
    for (int n = 0; n < NumPorts; n++) begin
      t    = $urandom % NumPorts;
      data = $urandom;
      @(posedge clk_i);
      clearInputs();
      req_i[n]   <= 1'b1;
      add_i[n]   <= addr_t'(t);
      wdata_i[n] <= data;
      gnt_i      <= '1;
      @(negedge clk_i);
      checkEq("req_o", req_o, 1 << t);
      checkEq("idx_o", idx_o[t], n);
      checkEq("wdata_o", wdata_o[t], data);
      checkEq("gnt_o", gnt_o, 1 << n);
    end
    @(posedge clk_i);
    clearInputs();
    endTest("single request", startErrors);
  endtask

  task automatic xorPermutations();
    int startErrors;
    logic [31:0] data [NumPorts];
    startErrors = errors;
    for (int c = 0; c < NumPorts; c++) begin
      @(posedge clk_i);
      clearInputs();
      gnt_i <= '1;
      for (int n = 0; n < NumPorts; n++) begin
        data[n]    = $urandom;
        req_i[n]   <= 1'b1;
        add_i[n]   <= addr_t'(n ^ c);
        wdata_i[n] <= data[n];
      end
      @(negedge clk_i);
      checkEq("gnt_o", gnt_o, {NumPorts{1'b1}});
      checkEq("req_o", req_o, {NumPorts{1'b1}});
      for (int n = 0; n < NumPorts; n++) begin
        checkEq("idx_o", idx_o[n ^ c], n);
        checkEq("wdata_o", wdata_o[n ^ c], data[n]);
      end
    end
    @(posedge clk_i);
    clearInputs();
    endTest("conflict-free permutations", startErrors);
  endtask

  task automatic contendPair(input int a, input int b, input int t);
    logic [31:0]         dataA;
    logic [31:0]         dataB;
    logic [NumPorts-1:0] pending;
    logic [NumPorts-1:0] granted;
    int                  winner;
    int                  cycles;
    dataA   = $urandom;
    dataB   = $urandom;
    pending = (1 << a) | (1 << b);
    cycles  = 0;
    @(posedge clk_i);
    clearInputs();
    req_i      <= pending;
    add_i[a]   <= addr_t'(t);
    add_i[b]   <= addr_t'(t);
    wdata_i[a] <= dataA;
    wdata_i[b] <= dataB;
    gnt_i      <= '1;
    // First cycle has both requests, the loser gets at most two more
    while (pending != 0 && cycles < 3) begin
      @(negedge clk_i);
      if (pending[a] && pending[b]) begin
        winner = predictWinner(a, b, prioModel);
      end else begin
        winner = pending[a] ? a : b;
      end
      granted = gnt_o;
      checkEq("gnt_o", granted, 1 << winner);
      checkEq("req_o", req_o, 1 << t);
      checkEq("idx_o", idx_o[t], winner);
      checkEq("wdata_o", wdata_o[t], (winner == a) ? dataA : dataB);
      @(posedge clk_i);
      pending = pending & ~granted;
      req_i <= pending;
      cycles++;
    end
    if (pending != 0) begin
      errors++;
      $display("Initiators %0d and %0d were not both granted target %0d in time", a, b, t);
    end
    clearInputs();
  endtask

  task automatic sharedTargets();
    int startErrors;
    int a;
    startErrors = errors;
    for (int i = 0; i < 8; i++) begin
      a = $urandom % NumPorts;
      contendPair(a, a ^ (1 + ($urandom % (NumPorts - 1))), $urandom % NumPorts);
    end
    endTest("contention", startErrors);
  endtask

  task automatic responseRouting();
    int startErrors;
    int t;
    logic [31:0] data;
    startErrors = errors;
    for (int n = 0; n < NumPorts; n++) begin
      t    = $urandom % NumPorts;
      data = $urandom;
      @(posedge clk_i);
      clearInputs();
      vld_i[t]   <= 1'b1;
      idx_i[t]   <= idx_t'(n);
      rdata_i[t] <= data;
      rdy_i      <= '1;
      @(negedge clk_i);
      checkEq("vld_o", vld_o, 1 << n);
      checkEq("rdata_o", rdata_o[n], data);
      checkEq("rdy_o", rdy_o, 1 << t);
    end
    @(posedge clk_i);
    clearInputs();
    endTest("response routing", startErrors);
  endtask

  task automatic backPressure();
    int startErrors;
    startErrors = errors;
    // Target 5 holds off a request from initiator 3
    @(posedge clk_i);
    clearInputs();
    req_i[3] <= 1'b1;
    add_i[3] <= addr_t'(5);
    @(negedge clk_i);
    checkEq("gnt_o", gnt_o, 0);
    checkEq("req_o", req_o, 1 << 5);
    checkEq("idx_o", idx_o[5], 3);
    // Initiator 3 holds off a response from target 5
    @(posedge clk_i);
    clearInputs();
    vld_i[5] <= 1'b1;
    idx_i[5] <= idx_t'(3);
    rdy_i    <= ~(NumPorts'(1) << 3);
    @(negedge clk_i);
    checkEq("vld_o", vld_o, 1 << 3);
    checkEq("rdy_o", rdy_o, 0);
    @(posedge clk_i);
    clearInputs();
    endTest("back-pressure", startErrors);
  endtask

  initial begin
    void'($urandom(75158));
    clearInputs();
    reset_i <= 1'b1;
    repeat (10) @(posedge clk_i);
    reset_i <= 1'b0;
    idleAfterReset();
    singleRequests();
    xorPermutations();
    sharedTargets();
    responseRouting();
    backPressure();
    $display("Tests passed: %0d, failed: %0d, errors: %0d", testsPassed, testsFailed, errors);
    if (testsFailed == 0 && errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule : butterflyNetTb

`default_nettype wire

//--- src/bflyPkg.sv
// Butterfly network types
`default_nettype none

`include "bflyConsts.svh"

package bflyPkg;

  // Target address, top bit steers the current stage
  typedef logic [`BFLY_ADDR_W-1:0] addr_t;

  // Initiator index, low bit steers the current response stage
  typedef logic [`BFLY_IDX_W-1:0] idx_t;

  typedef logic [`BFLY_REQ_DATA_W-1:0] reqData_t;
  typedef logic [`BFLY_RESP_DATA_W-1:0] respData_t;

  // Round-robin state, stage l uses bit (STAGES-1-l)
  typedef logic [`BFLY_STAGES-1:0] prio_t;

  // Request flit between switchboxes
  typedef struct packed {
    addr_t    addr;
    idx_t     idx;
    reqData_t data;
  } reqFlit_t;

  // Response flit between switchboxes
  typedef struct packed {
    idx_t      idx;
    respData_t data;
  } respFlit_t;

endpackage : bflyPkg

`default_nettype wire

//--- src/bflySwitch.sv
// Butterfly 2x2 switchbox
`timescale 1ns/1ps
`default_nettype none

`include "bflyConsts.svh"

module bflySwitch (
  // Tie-break bit of this stage
  input  logic                     prio_i,
  // Request path, initiator side
  input  logic [1:0]               reqIn_i,
  input  bflyPkg::reqFlit_t [1:0]  reqFlitIn_i,
  output logic [1:0]               gntIn_o,
  // Request path, target side
  output logic [1:0]               reqOut_o,
  output bflyPkg::reqFlit_t [1:0]  reqFlitOut_o,
  input  logic [1:0]               gntOut_i,
  // Response path, target side
  input  logic [1:0]               vldIn_i,
  input  bflyPkg::respFlit_t [1:0] respFlitIn_i,
  output logic [1:0]               rdyIn_o,
  // Response path, initiator side
  output logic [1:0]               vldOut_o,
  output bflyPkg::respFlit_t [1:0] respFlitOut_o,
  input  logic [1:0]               rdyOut_i
);

  import bflyPkg::*;

  // Steering bit of each incoming flit
  logic [1:0] reqDst;
  logic [1:0] respDst;

  // Per output port: some input wants it, and the winning input
  logic [1:0] reqHit;
  logic [1:0] reqSel;
  logic [1:0] respHit;
  logic [1:0] respSel;

  // Winning flits before the address/index update
  reqFlit_t  [1:0] reqWin;
  respFlit_t [1:0] respWin;

  // Arbitration of one output port, returns {hit, sel}
  function automatic logic [1:0] arbitrate(
    input logic [1:0] act,
    input logic [1:0] dst,
    input logic       outPort,
    input logic       prio
  );
    logic want0;
    logic want1;
    logic sel;
    want0 = act[0] && (dst[0] == outPort);
    want1 = act[1] && (dst[1] == outPort);
    // On a conflict the input numbered like the priority bit wins
    if (want0 && want1) begin
      sel = prio;
    end else begin
      sel = want1;
    end
    return {want0 | want1, sel};
  endfunction

  // Request path

  // Top address bit picks the output
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      reqDst[i] = reqFlitIn_i[i].addr[`BFLY_ADDR_W-1];
    end
  end

  always_comb begin
    for (int o = 0; o < 2; o++) begin
      {reqHit[o], reqSel[o]} = arbitrate(reqIn_i, reqDst, 1'(o), prio_i);
    end
  end

  // Forward the winner, next stage sees the next address bit on top
  always_comb begin
    for (int o = 0; o < 2; o++) begin
      reqWin[o]            = reqFlitIn_i[reqSel[o]];
      reqOut_o[o]          = reqHit[o];
      reqFlitOut_o[o].addr = reqWin[o].addr << 1;
      // Arrival port enters the index from the low end
      reqFlitOut_o[o].idx  = {reqWin[o].idx[`BFLY_IDX_W-2:0], reqSel[o]};
      reqFlitOut_o[o].data = reqWin[o].data;
    end
  end

  // Only the winner of its output sees the downstream grant
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      gntIn_o[i] = reqIn_i[i]
                   && (reqSel[reqDst[i]] == 1'(i))
                   && gntOut_i[reqDst[i]];
    end
  end

  // Response path

  // Low index bit picks the initiator-side port
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      respDst[i] = respFlitIn_i[i].idx[0];
    end
  end

  always_comb begin
    for (int o = 0; o < 2; o++) begin
      {respHit[o], respSel[o]} = arbitrate(vldIn_i, respDst, 1'(o), prio_i);
    end
  end

  // Consumed index bit drops off the low end
  always_comb begin
    for (int o = 0; o < 2; o++) begin
      respWin[o]            = respFlitIn_i[respSel[o]];
      vldOut_o[o]           = respHit[o];
      respFlitOut_o[o].idx  = respWin[o].idx >> 1;
      respFlitOut_o[o].data = respWin[o].data;
    end
  end

  // Ready back to the winning target-side port only
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rdyIn_o[i] = vldIn_i[i]
                   && (respSel[respDst[i]] == 1'(i))
                   && rdyOut_i[respDst[i]];
    end
  end

endmodule : bflySwitch

`default_nettype wire

//--- src/butterflyNet.sv
// Radix-2 butterfly interconnect
`timescale 1ns/1ps
`default_nettype none

`include "bflyConsts.svh"

module butterflyNet (
  input  logic                                     clk_i,
  input  logic                                     reset_i,
  // Initiator side
  input  logic [`BFLY_NUM_PORTS-1:0]               req_i,
  input  bflyPkg::addr_t [`BFLY_NUM_PORTS-1:0]     add_i,
  input  bflyPkg::reqData_t [`BFLY_NUM_PORTS-1:0]  wdata_i,
  output logic [`BFLY_NUM_PORTS-1:0]               gnt_o,
  output logic [`BFLY_NUM_PORTS-1:0]               vld_o,
  output bflyPkg::respData_t [`BFLY_NUM_PORTS-1:0] rdata_o,
  input  logic [`BFLY_NUM_PORTS-1:0]               rdy_i,
  // Target side
  output logic [`BFLY_NUM_PORTS-1:0]               req_o,
  output bflyPkg::idx_t [`BFLY_NUM_PORTS-1:0]      idx_o,
  output bflyPkg::reqData_t [`BFLY_NUM_PORTS-1:0]  wdata_o,
  input  logic [`BFLY_NUM_PORTS-1:0]               gnt_i,
  input  logic [`BFLY_NUM_PORTS-1:0]               vld_i,
  input  bflyPkg::idx_t [`BFLY_NUM_PORTS-1:0]      idx_i,
  input  bflyPkg::respData_t [`BFLY_NUM_PORTS-1:0] rdata_i,
  output logic [`BFLY_NUM_PORTS-1:0]               rdy_o
);

  import bflyPkg::*;

  localparam int unsigned NumPorts    = `BFLY_NUM_PORTS;
  localparam int unsigned NumStages   = `BFLY_STAGES;
  localparam int unsigned NumSwitches = NumPorts / 2;

  // Butterfly permutation: position in stage l+1 fed by output pos of stage l
  function automatic int unsigned linkPos(input int unsigned l, input int unsigned pos);
    int unsigned r;
    int unsigned s;
    int unsigned pw;
    int unsigned k;
    int unsigned j;
    r  = pos / 2;
    s  = pos % 2;
    pw = 1 << (NumStages - l - 2);
    k  = pw * s + (r % pw) + (r / pw / 2) * pw * 2;
    j  = (r / pw) % 2;
    return 2 * k + j;
  endfunction

  // Initiator on first-stage position pos, a rotate right by one bit.
  // This order makes the collected index equal the initiator number
  function automatic int unsigned initPort(input int unsigned pos);
    return (pos >> 1) | ((pos & 1) << (NumStages - 1));
  endfunction

  prio_t prio;
  logic  accept;

  // Any accepted target handshake moves the priority on
  assign accept = |(req_o & gnt_i);

  prioCounter uPrioCounter (
    .clk_i   (clk_i  ),
    .reset_i (reset_i),
    .accept_i(accept ),
    .prio_o  (prio   )
  );

  for (genvar l = 0; l < NumStages; l++) begin : gStage
    // Request path, In faces the initiators
    logic     [NumPorts-1:0] reqIn;
    reqFlit_t [NumPorts-1:0] reqFlitIn;
    logic     [NumPorts-1:0] gntIn;
    logic     [NumPorts-1:0] reqOut;
    reqFlit_t [NumPorts-1:0] reqFlitOut;
    logic     [NumPorts-1:0] gntOut;
    // Response path, In faces the targets
    logic      [NumPorts-1:0] vldIn;
    respFlit_t [NumPorts-1:0] respFlitIn;
    logic      [NumPorts-1:0] rdyIn;
    logic      [NumPorts-1:0] vldOut;
    respFlit_t [NumPorts-1:0] respFlitOut;
    logic      [NumPorts-1:0] rdyOut;

    // Initiator-facing side of the stage
    if (l == 0) begin : gInit
      for (genvar p = 0; p < NumPorts; p++) begin : gPort
        localparam int unsigned N = initPort(p);
        assign reqIn[p]     = req_i[N];
        // Index starts empty and fills up one bit per stage
        assign reqFlitIn[p] = '{addr: add_i[N], idx: '0, data: wdata_i[N]};
        assign gnt_o[N]     = gntIn[p];
        assign vld_o[N]     = vldOut[p];
        assign rdata_o[N]   = respFlitOut[p].data;
        assign rdyOut[p]    = rdy_i[N];
      end
    end else begin : gLinkIn
      for (genvar p = 0; p < NumPorts; p++) begin : gPort
        localparam int unsigned Q = linkPos(l - 1, p);
        assign reqIn[Q]     = gStage[l-1].reqOut[p];
        assign reqFlitIn[Q] = gStage[l-1].reqFlitOut[p];
        assign rdyOut[Q]    = gStage[l-1].rdyIn[p];
      end
    end

    // Target-facing side of the stage
    if (l == NumStages - 1) begin : gTarget
      for (genvar p = 0; p < NumPorts; p++) begin : gPort
        assign req_o[p]      = reqOut[p];
        assign idx_o[p]      = reqFlitOut[p].idx;
        assign wdata_o[p]    = reqFlitOut[p].data;
        assign gntOut[p]     = gnt_i[p];
        assign vldIn[p]      = vld_i[p];
        assign respFlitIn[p] = '{idx: idx_i[p], data: rdata_i[p]};
        assign rdy_o[p]      = rdyIn[p];
      end
    end else begin : gLinkOut
      for (genvar p = 0; p < NumPorts; p++) begin : gPort
        localparam int unsigned Q = linkPos(l, p);
        assign gntOut[p]     = gStage[l+1].gntIn[Q];
        assign vldIn[p]      = gStage[l+1].vldOut[Q];
        assign respFlitIn[p] = gStage[l+1].respFlitOut[Q];
      end
    end

    // Switchbox r owns positions 2r and 2r+1 on both sides
    for (genvar r = 0; r < NumSwitches; r++) begin : gSwitch
      bflySwitch uSwitch (
        .prio_i       (prio[NumStages-1-l]  ),
        .reqIn_i      (reqIn[2*r +: 2]      ),
        .reqFlitIn_i  (reqFlitIn[2*r +: 2]  ),
        .gntIn_o      (gntIn[2*r +: 2]      ),
        .reqOut_o     (reqOut[2*r +: 2]     ),
        .reqFlitOut_o (reqFlitOut[2*r +: 2] ),
        .gntOut_i     (gntOut[2*r +: 2]     ),
        .vldIn_i      (vldIn[2*r +: 2]      ),
        .respFlitIn_i (respFlitIn[2*r +: 2] ),
        .rdyIn_o      (rdyIn[2*r +: 2]      ),
        .vldOut_o     (vldOut[2*r +: 2]     ),
        .respFlitOut_o(respFlitOut[2*r +: 2]),
        .rdyOut_i     (rdyOut[2*r +: 2]     )
      );
    end
  end

endmodule : butterflyNet

`default_nettype wire

//--- src/prioCounter.sv
// Round-robin priority counter
`timescale 1ns/1ps
`default_nettype none

module prioCounter (
  input  logic           clk_i,
  input  logic           reset_i,
  // High when any target completes a request handshake
  input  logic           accept_i,
  output bflyPkg::prio_t prio_o
);

  import bflyPkg::*;

  prio_t count;

  // Wraps modulo the port count
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count <= '0;
    end else if (accept_i) begin
      count <= count + prio_t'(1);
    end
  end

  // Each stage taps its own bit, low bits toggle fastest
  assign prio_o = count;

endmodule : prioCounter

`default_nettype wire

//--- tb.f
+incdir+include
src/bflyPkg.sv
src/bflySwitch.sv
src/prioCounter.sv
src/butterflyNet.sv
sim/butterflyNetTb.sv
